//--- all.f
src/rvPkg.sv
src/instDecoder.sv
src/regFile.sv
src/aluUnit.sv
src/nextPcUnit.sv
src/loadStoreWriteback.sv
src/rvCore.sv
bench/rvCore_properties.sv
bench/rvCoreTb.sv

//--- bench/rvCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module rvCoreTb;
	localparam logic [31:0] RESET_PC       = 32'h8000_0000;
	localparam int          RETIRE_TIMEOUT = 10;

	logic        clk;
	logic        rst;
	logic        instValid;
	logic [31:0] inst;
	logic [31:0] pc;
	logic        retireValid;
	logic [4:0]  retireRd;
	logic [31:0] retireData;
	logic        retireInvalid;

	logic [31:0] lfsr;
	logic [31:0] regs [32]; // reference model state
	logic [31:0] dmem [256];
	logic [31:0] modelPc;
	logic [31:0] curWord;
	string       testName;
	int          checks, errors, testErrors, testCount;
	bit          aborted;

	rvCore u_dut (
		.clk           (clk),
		.rst           (rst),
		.instValid     (instValid),
		.inst          (inst),
		.pc            (pc),
		.retireValid   (retireValid),
		.retireRd      (retireRd),
		.retireData    (retireData),
		.retireInvalid (retireInvalid)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r    = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3:    return (a < b) ? 32'd1 : 32'd0;
			3'd4:    return a ^ b;
			3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] genArith();
		logic [2:0]  kind, f3;
		logic [4:0]  rd, rs1, rs2;
		logic [11:0] imm12;
		logic [6:0]  f7;
		kind  = 3'(takeBits(3));
		rd    = 5'(takeBits(5)); // x0 included on purpose
		rs1   = 5'(takeBits(5));
		rs2   = 5'(takeBits(5));
		f3    = 3'(takeBits(3));
		imm12 = 12'(takeBits(12));
		f7    = (takeBits(1) == 32'd1 && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
		case (kind)
			3'd0: return {20'(takeBits(20)), rd, rvPkg::OPC_LUI};
			3'd1: return {20'(takeBits(20)), rd, rvPkg::OPC_AUIPC};
			3'd2, 3'd3, 3'd4: begin
				if (f3 == 3'd1)
					imm12[11:5] = 7'h00;
				else if (f3 == 3'd5)
					imm12[11:5] = f7; // srli or srai
				return {imm12, rs1, f3, rd, rvPkg::OPC_OPIMM};
			end
			default: return {f7, rs2, rs1, f3, rd, rvPkg::OPC_OP};
		endcase
	endfunction

	// loads and stores off x0 within the first 64 bytes, naturally aligned
	function automatic logic [31:0] genMem();
		logic [4:0]  rd, rs2;
		logic [2:0]  f3;
		logic [11:0] ofs;
		rd  = 5'(takeBits(5));
		rs2 = 5'(takeBits(5));
		ofs = {6'd0, 6'(takeBits(6))};
		f3  = 3'(takeBits(3));
		if (f3 == 3'd3)
			f3 = 3'd2;
		else if (f3[2])
			f3 = {2'b10, f3[0]}; // lbu, lhu
		if (f3[1:0] == 2'd1)
			ofs[0] = 1'b0;
		else if (f3[1:0] == 2'd2)
			ofs[1:0] = 2'd0;
		if (takeBits(1) == 32'd1 && !f3[2])
			return {ofs[11:5], rs2, 5'd0, f3, ofs[4:0], rvPkg::OPC_STORE};
		return {ofs, 5'd0, f3, rd, rvPkg::OPC_LOAD};
	endfunction

	function automatic logic [31:0] genFlow();
		logic [1:0] kind;
		logic [2:0] f3;
		logic [4:0] rd, rs1, rs2;
		kind = 2'(takeBits(2));
		rd   = 5'(takeBits(5));
		rs1  = 5'(takeBits(5));
		rs2  = 5'(takeBits(5));
		f3   = 3'(takeBits(3));
		if (takeBits(1) == 32'd1)
			rs2 = rs1; // equal operands now and then
		if (!f3[2])
			f3[1] = 1'b0; // beq and bne only
		case (kind)
			2'd0: return {20'(takeBits(20)), rd, rvPkg::OPC_JAL};
			2'd1: return {12'(takeBits(12)), rs1, 3'd0, rd, rvPkg::OPC_JALR};
			default: return {7'(takeBits(7)), rs2, rs1, f3, 5'(takeBits(5)), rvPkg::OPC_BRANCH};
		endcase
	endfunction

	function automatic logic [31:0] genInvalid();
		logic [31:0] w;
		logic [2:0]  sel;
		w   = takeBits(32);
		sel = 3'(takeBits(3));
		case (sel)
			3'd4:    return {w[31:15], 2'b01, w[12:7], rvPkg::OPC_BRANCH}; // funct3 2 or 3
			3'd5:    return {w[31:15], 2'b11, w[12:7], rvPkg::OPC_LOAD};
			3'd6:    return {w[31:15], 1'b1, w[13:7], rvPkg::OPC_STORE};
			3'd7:    return {7'h01, w[24:7], rvPkg::OPC_OP}; // M extension
			default: return {w[31:1], 1'b0}; // low opcode bits not 11
		endcase
	endfunction

	// executes one word on the model state by the RV32I rules
	task automatic modelStep(input logic [31:0] w, output logic [4:0] eRd,
		output logic [31:0] eData, output logic eInv);
		rvPkg::instWord_u u;
		logic [31:0] a, b, immI, immS, immB, immJ, immU, res, nextPc, addr, memWord;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [7:0]  by;
		logic [15:0] hw;
		logic        wr, inv, taken;
		u      = w;
		f3     = u.rType.funct3;
		f7     = u.rType.funct7;
		a      = regs[u.rType.rs1];
		b      = regs[u.rType.rs2];
		immI   = {{20{u.iType.imm[11]}}, u.iType.imm};
		immS   = {{20{u.sType.immHi[6]}}, u.sType.immHi, u.sType.immLo};
		immB   = {{20{u.bType.imm12}}, u.bType.imm11, u.bType.imm10to5, u.bType.imm4to1, 1'b0};
		immJ   = {{12{u.jType.imm20}}, u.jType.imm19to12, u.jType.imm11, u.jType.imm10to1, 1'b0};
		immU   = {u.uType.imm, 12'd0};
		res    = 32'd0;
		wr     = 1'b0;
		inv    = 1'b0;
		taken  = 1'b0;
		nextPc = modelPc + 32'd4;
		case (u.rType.opcode)
			rvPkg::OPC_LUI: begin
				res = immU;
				wr  = 1'b1;
			end
			rvPkg::OPC_AUIPC: begin
				res = modelPc + immU;
				wr  = 1'b1;
			end
			rvPkg::OPC_JAL: begin
				res    = modelPc + 32'd4;
				nextPc = modelPc + immJ;
				wr     = 1'b1;
			end
			rvPkg::OPC_JALR: begin
				inv    = (f3 != 3'd0);
				res    = modelPc + 32'd4;
				nextPc = (a + immI) & ~32'd1;
				wr     = 1'b1;
			end
			rvPkg::OPC_BRANCH: begin
				case (f3)
					3'd0:    taken = (a == b);
					3'd1:    taken = (a != b);
					3'd4:    taken = ($signed(a) < $signed(b));
					3'd5:    taken = ($signed(a) >= $signed(b));
					3'd6:    taken = (a < b);
					3'd7:    taken = (a >= b);
					default: inv = 1'b1;
				endcase
				if (taken)
					nextPc = modelPc + immB;
			end
			rvPkg::OPC_LOAD: begin
				addr    = a + immI;
				memWord = dmem[addr[9:2]];
				by      = memWord[{addr[1:0], 3'b000} +: 8];
				hw      = memWord[{addr[1], 4'b0000} +: 16];
				wr      = 1'b1;
				case (f3)
					3'd0:    res = {{24{by[7]}}, by};
					3'd1:    res = {{16{hw[15]}}, hw};
					3'd2:    res = memWord;
					3'd4:    res = {24'd0, by};
					3'd5:    res = {16'd0, hw};
					default: inv = 1'b1;
				endcase
			end
			rvPkg::OPC_STORE: begin
				addr = a + immS;
				case (f3)
					3'd0:    dmem[addr[9:2]][{addr[1:0], 3'b000} +: 8] = b[7:0];
					3'd1:    dmem[addr[9:2]][{addr[1], 4'b0000} +: 16] = b[15:0];
					3'd2:    dmem[addr[9:2]] = b;
					default: inv = 1'b1;
				endcase
			end
			rvPkg::OPC_OPIMM: begin
				wr = 1'b1;
				if (f3 == 3'd1)
					inv = (f7 != 7'h00);
				else if (f3 == 3'd5)
					inv = (f7 != 7'h00) && (f7 != 7'h20);
				res = aluRef(f3, (f3 == 3'd5) && f7[5], a, immI);
			end
			rvPkg::OPC_OP: begin
				wr  = 1'b1;
				inv = !((f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
				res = aluRef(f3, f7 == 7'h20, a, b);
			end
			default: inv = 1'b1;
		endcase
		if (inv) begin
			wr     = 1'b0;
			nextPc = modelPc + 32'd4;
		end
		eInv = inv;
		if (wr && u.rType.rd != 5'd0) begin
			regs[u.rType.rd] = res;
			eRd              = u.rType.rd;
			eData            = res;
		end else begin
			eRd   = 5'd0;
			eData = 32'd0;
		end
		modelPc = nextPc;
	endtask

	task automatic checkEq(input string field, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			testErrors++;
			$display("Mismatch %s %s (inst %h): expected %h, actual %h",
				testName, field, curWord, expected, actual);
		end
	endtask

	task automatic waitRetire(output bit ok);
		int cycles;
		cycles = 0;
		while (!retireValid && cycles < RETIRE_TIMEOUT) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		ok = retireValid;
		if (!ok)
			$display("Timeout in %s: no retireValid within %0d cycles after a strobe",
				testName, RETIRE_TIMEOUT);
	endtask

	// one strobe, then gap idle cycles
	task automatic runInst(input logic [31:0] w, input int gap);
		logic [4:0]  eRd;
		logic [31:0] eData;
		logic        eInv;
		bit          ok;
		curWord   = w;
		instValid = 1'b1;
		inst      = w;
		modelStep(w, eRd, eData, eInv);
		@(posedge clk);
		#2;
		instValid = 1'b0;
		inst      = takeBits(32); // don't care while idle
		waitRetire(ok);
		if (!ok) begin
			aborted = 1'b1;
		end else begin
			checkEq("retireRd", {27'd0, eRd}, {27'd0, retireRd});
			checkEq("retireData", eData, retireData);
			checkEq("retireInvalid", {31'd0, eInv}, {31'd0, retireInvalid});
			checkEq("pc", modelPc, pc);
			testCount++;
			repeat (gap) begin
				@(posedge clk);
				#2;
			end
		end
	endtask

	task automatic runTest(input string name, input int kind, input int count,
		input bit withGaps);
		logic [31:0] w;
		int          sel, gap;
		testName   = name;
		testErrors = 0;
		testCount  = 0;
		for (int i = 0; i < count && !aborted; i++) begin
			sel = (kind == 4) ? int'(takeBits(2)) : kind; // kind 4 mixes all four
			gap = withGaps ? int'(takeBits(2)) : 0;
			case (sel)
				0:       w = genArith();
				1:       w = genMem();
				2:       w = genFlow();
				3:       w = genInvalid();
				default: w = {12'(4 * i), 5'd0, 3'd2, 5'd1, rvPkg::OPC_LOAD}; // lw x1 sweep
			endcase
			runInst(w, gap);
		end
		$display("test %s: %0d instructions, %0d errors", name, testCount, testErrors);
	endtask

	initial begin
		lfsr      = 32'h254f;
		rst       = 1'b1;
		instValid = 1'b0;
		inst      = 32'd0;
		curWord   = 32'd0;
		modelPc   = RESET_PC;
		checks    = 0;
		errors    = 0;
		aborted   = 1'b0;
		for (int i = 0; i < 32; i++)
			regs[i] = 32'd0;
		for (int i = 0; i < 256; i++)
			dmem[i] = 32'd0;
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;

		testName   = "reset";
		testErrors = 0;
		repeat (3) begin
			checkEq("pc", RESET_PC, pc);
			checks++;
			if (retireValid) begin
				errors++;
				testErrors++;
				$display("reset: retireValid rose before the first strobe");
			end
			@(posedge clk);
			#2;
		end
		$display("test reset: %0d errors", testErrors);

		runTest("alu", 0, 300, 1'b0);
		runTest("load/store", 1, 300, 1'b0);
		runTest("branch/jump", 2, 200, 1'b0);
		runTest("invalid", 3, 100, 1'b0);
		runTest("memory sweep", 5, 256, 1'b0);
		runTest("mixed with gaps", 4, 400, 1'b1);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0 && !aborted)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/rvCore_properties.sv
`timescale 1ns/100ps
`default_nettype none

module rvCoreProperties (
	input logic        clk,
	input logic        rst,
	input logic        instValid,
	input logic [31:0] pc,
	input logic        retireValid,
	input logic [4:0]  retireRd,
	input logic [31:0] retireData,
	input logic        retireInvalid
);
	// retirement trails the strobe by exactly one cycle
	retireAfterStrobe: assert property (@(posedge clk) disable iff (rst)
		instValid |=> retireValid)
		else $error("retireValid missing one cycle after a strobe");

	noRetireWithoutStrobe: assert property (@(posedge clk) disable iff (rst)
		!instValid |=> !retireValid)
		else $error("retireValid high without a strobe one cycle before");

	pcHeldBetweenStrobes: assert property (@(posedge clk) disable iff (rst)
		!instValid |=> $stable(pc))
		else $error("pc moved on a cycle without a strobe");

	// an invalid word reports no write
	invalidWritesNothing: assert property (@(posedge clk) disable iff (rst)
		retireInvalid |-> (retireRd == 5'd0 && retireData == 32'd0))
		else $error("invalid instruction retired with a register write");

endmodule

bind rvCore rvCoreProperties u_props (
	.clk           (clk),
	.rst           (rst),
	.instValid     (instValid),
	.pc            (pc),
	.retireValid   (retireValid),
	.retireRd      (retireRd),
	.retireData    (retireData),
	.retireInvalid (retireInvalid)
);

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module rvCoreTb -f all.f
./obj_dir/VrvCoreTb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
if grep -q "Checks failed" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation ok"

//--- src/aluUnit.sv
`timescale 1ns/100ps
`default_nettype none

module aluUnit (
	input  logic [rvPkg::ALU_OP_W-1:0] aluOp,
	input  logic                       aluSrcImm,
	input  logic                       useAuipc,
	input  logic [31:0]                rs1Data,
	input  logic [31:0]                rs2Data,
	input  logic [31:0]                imm,
	input  logic [31:0]                pc,
	output logic [31:0]                aluResult
);
	logic [31:0] opA, opB;
	logic [4:0]  shamt;

	assign opA   = useAuipc ? pc : rs1Data;
	assign opB   = aluSrcImm ? imm : rs2Data;
	assign shamt = opB[4:0];

	always_comb begin
		case (aluOp)
			rvPkg::ALU_ADD:   aluResult = opA + opB;
			rvPkg::ALU_SUB:   aluResult = opA - opB;
			rvPkg::ALU_SLL:   aluResult = opA << shamt;
			rvPkg::ALU_SLT:   aluResult = {31'd0, $signed(opA) < $signed(opB)};
			rvPkg::ALU_SLTU:  aluResult = {31'd0, opA < opB};
			rvPkg::ALU_XOR:   aluResult = opA ^ opB;
			rvPkg::ALU_SRL:   aluResult = opA >> shamt;
			rvPkg::ALU_SRA:   aluResult = $unsigned($signed(opA) >>> shamt);
			rvPkg::ALU_OR:    aluResult = opA | opB;
			rvPkg::ALU_AND:   aluResult = opA & opB;
			rvPkg::ALU_PASSB: aluResult = opB;
			default:          aluResult = 32'd0;
		endcase
	end

endmodule

`default_nettype wire

//--- src/instDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module instDecoder (
	input  logic [31:0]                inst,
	output logic [rvPkg::ALU_OP_W-1:0] aluOp,
	output logic                       aluSrcImm,
	output logic                       useAuipc,
	output logic                       regWrite,
	output logic [1:0]                 wbSel,
	output logic                       isBranch,
	output logic                       isJal,
	output logic                       isJalr,
	output logic                       memRead,
	output logic                       memWrite,
	output logic [2:0]                 memFunct3,
	output logic [31:0]                imm,
	output logic                       invalid
);
	rvPkg::instWord_u word;
	logic [31:0] immI, immS, immB, immU, immJ;
	logic [2:0]  f3;
	logic        zeroF7; // funct7 == 0000000
	logic        altF7;  // funct7 == 0100000, sub and sra

	assign word   = inst;
	assign f3     = word.rType.funct3;
	assign zeroF7 = (word.rType.funct7 == 7'b0000000);
	assign altF7  = (word.rType.funct7 == 7'b0100000);

	assign immI = {{20{word.iType.imm[11]}}, word.iType.imm};
	assign immS = {{20{word.sType.immHi[6]}}, word.sType.immHi, word.sType.immLo};
	assign immB = {{19{word.bType.imm12}}, word.bType.imm12, word.bType.imm11,
		word.bType.imm10to5, word.bType.imm4to1, 1'b0};
	assign immU = {word.uType.imm, 12'b0};
	assign immJ = {{11{word.jType.imm20}}, word.jType.imm20, word.jType.imm19to12,
		word.jType.imm11, word.jType.imm10to1, 1'b0};

	assign memFunct3 = f3;

	always_comb begin
		aluOp     = rvPkg::ALU_ADD;
		aluSrcImm = 1'b0;
		useAuipc  = 1'b0;
		regWrite  = 1'b0;
		wbSel     = rvPkg::WB_ALU;
		isBranch  = 1'b0;
		isJal     = 1'b0;
		isJalr    = 1'b0;
		memRead   = 1'b0;
		memWrite  = 1'b0;
		imm       = immI;
		invalid   = 1'b0;

		case (word.rType.opcode)
			rvPkg::OPC_LUI: begin
				aluOp     = rvPkg::ALU_PASSB;
				aluSrcImm = 1'b1;
				regWrite  = 1'b1;
				imm       = immU;
			end
			rvPkg::OPC_AUIPC: begin
				aluSrcImm = 1'b1;
				useAuipc  = 1'b1; // operand a is pc
				regWrite  = 1'b1;
				imm       = immU;
			end
			rvPkg::OPC_JAL: begin
				isJal    = 1'b1;
				regWrite = 1'b1;
				wbSel    = rvPkg::WB_LINK;
				imm      = immJ;
			end
			rvPkg::OPC_JALR: begin
				isJalr   = 1'b1;
				regWrite = 1'b1;
				wbSel    = rvPkg::WB_LINK;
				invalid  = (f3 != 3'd0);
			end
			rvPkg::OPC_BRANCH: begin
				isBranch = 1'b1;
				imm      = immB;
				invalid  = (f3 == 3'd2) || (f3 == 3'd3);
			end
			rvPkg::OPC_LOAD: begin
				aluSrcImm = 1'b1; // address = rs1 + imm
				memRead   = 1'b1;
				regWrite  = 1'b1;
				wbSel     = rvPkg::WB_LOAD;
				invalid   = (f3 == 3'd3) || (f3 == 3'd6) || (f3 == 3'd7);
			end
			rvPkg::OPC_STORE: begin
				aluSrcImm = 1'b1;
				memWrite  = 1'b1;
				imm       = immS;
				invalid   = (f3 > 3'd2);
			end
			rvPkg::OPC_OPIMM, rvPkg::OPC_OP: begin
				aluSrcImm = (word.rType.opcode == rvPkg::OPC_OPIMM);
				regWrite  = 1'b1;
				case (f3)
					3'd0: aluOp = (!aluSrcImm && altF7) ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
					3'd1: aluOp = rvPkg::ALU_SLL;
					3'd2: aluOp = rvPkg::ALU_SLT;
					3'd3: aluOp = rvPkg::ALU_SLTU;
					3'd4: aluOp = rvPkg::ALU_XOR;
					3'd5: aluOp = altF7 ? rvPkg::ALU_SRA : rvPkg::ALU_SRL;
					3'd6: aluOp = rvPkg::ALU_OR;
					default: aluOp = rvPkg::ALU_AND;
				endcase
				// immediates carry no funct7 except for shifts
				if (aluSrcImm)
					invalid = ((f3 == 3'd1) && !zeroF7) || ((f3 == 3'd5) && !(zeroF7 || altF7));
				else
					invalid = !(zeroF7 || (altF7 && ((f3 == 3'd0) || (f3 == 3'd5))));
			end
			default: invalid = 1'b1;
		endcase

		if (invalid) begin
			regWrite = 1'b0;
			memRead  = 1'b0;
			memWrite = 1'b0;
			isBranch = 1'b0;
			isJal    = 1'b0;
			isJalr   = 1'b0;
		end
		if (word.rType.rd == 5'd0)
			regWrite = 1'b0; // x0 writes are dropped
	end

endmodule

`default_nettype wire

//--- src/loadStoreWriteback.sv
`timescale 1ns/100ps
`default_nettype none

module loadStoreWriteback #(
	parameter DMEM_WORDS = 256
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        instValid,
	input  logic        memRead,
	input  logic        memWrite,
	input  logic [2:0]  memFunct3,
	input  logic        regWrite,
	input  logic [1:0]  wbSel,
	input  logic [31:0] aluResult,
	input  logic [31:0] rs2Data,
	input  logic [31:0] linkAddr,
	output logic [31:0] wbData,
	output logic        we
);
	localparam IDX_W = $clog2(DMEM_WORDS);

	logic [31:0]      mem [DMEM_WORDS];
	logic [IDX_W-1:0] wordIdx;
	logic [1:0]       offset;
	logic [3:0]       byteEn;
	logic [31:0]      stData;
	logic [31:0]      rdWord, shifted, loadData;
	logic [15:0]      halfSel;

	// byte address wraps modulo the memory size
	assign wordIdx = aluResult[IDX_W+1:2];
	assign offset  = aluResult[1:0];

	// halfwords use bit 1 only, words ignore the low bits
	always_comb begin
		case (memFunct3[1:0])
			2'b00: begin
				byteEn = 4'b0001 << offset;
				stData = {4{rs2Data[7:0]}};
			end
			2'b01: begin
				byteEn = offset[1] ? 4'b1100 : 4'b0011;
				stData = {2{rs2Data[15:0]}};
			end
			default: begin
				byteEn = 4'b1111;
				stData = rs2Data;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DMEM_WORDS; i++)
				mem[i] <= '0;
		end else if (instValid && memWrite) begin
			for (int b = 0; b < 4; b++)
				if (byteEn[b])
					mem[wordIdx][8*b +: 8] <= stData[8*b +: 8];
		end
	end

	// reads see the contents from before this edge
	assign rdWord  = memRead ? mem[wordIdx] : 32'd0;
	assign shifted = rdWord >> {offset, 3'b000};
	assign halfSel = offset[1] ? rdWord[31:16] : rdWord[15:0];

	always_comb begin
		case (memFunct3)
			3'd0:    loadData = {{24{shifted[7]}}, shifted[7:0]}; // lb
			3'd1:    loadData = {{16{halfSel[15]}}, halfSel};      // lh
			3'd4:    loadData = {24'd0, shifted[7:0]};
			3'd5:    loadData = {16'd0, halfSel};
			default: loadData = rdWord;
		endcase
	end

	always_comb begin
		case (wbSel)
			rvPkg::WB_LOAD: wbData = loadData;
			rvPkg::WB_LINK: wbData = linkAddr;
			default:        wbData = aluResult;
		endcase
	end

	assign we = regWrite && instValid;

endmodule

`default_nettype wire

//--- src/nextPcUnit.sv
`timescale 1ns/100ps
`default_nettype none

module nextPcUnit #(
	parameter logic [31:0] RESET_PC = 32'h8000_0000
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        instValid,
	input  logic        isBranch,
	input  logic        isJal,
	input  logic        isJalr,
	input  logic [2:0]  funct3,
	input  logic [31:0] rs1Data,
	input  logic [31:0] rs2Data,
	input  logic [31:0] imm,
	output logic [31:0] pc,
	output logic [31:0] linkAddr
);
	logic        taken;
	logic [31:0] pcTarget, jalrTarget, nextPc;

	// own comparator so this runs beside the alu
	always_comb begin
		case (funct3)
			3'd0:    taken = (rs1Data == rs2Data);
			3'd1:    taken = (rs1Data != rs2Data);
			3'd4:    taken = $signed(rs1Data) < $signed(rs2Data);
			3'd5:    taken = $signed(rs1Data) >= $signed(rs2Data);
			3'd6:    taken = rs1Data < rs2Data;
			3'd7:    taken = rs1Data >= rs2Data;
			default: taken = 1'b0;
		endcase
	end

	assign pcTarget   = pc + imm; // branch and jal
	assign jalrTarget = (rs1Data + imm) & ~32'd1;
	assign linkAddr   = pc + 32'd4;

	assign nextPc = isJalr ? jalrTarget :
		(isJal || (isBranch && taken)) ? pcTarget : linkAddr;

	always_ff @(posedge clk) begin
		if (rst)
			pc <= RESET_PC;
		else if (instValid)
			pc <= nextPc; // held between strobes
	end

endmodule

`default_nettype wire

//--- src/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
	input  logic        clk,
	input  logic        rst,
	input  logic        we,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	input  logic [4:0]  rd,
	input  logic [31:0] wdata,
	output logic [31:0] rs1Data,
	output logic [31:0] rs2Data
);
	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && (rd != 5'd0)) begin
			regs[rd] <= wdata;
		end
	end

	// asynchronous read, x0 hardwired
	assign rs1Data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
	assign rs2Data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

//--- src/rvCore.sv
`timescale 1ns/100ps
`default_nettype none

module rvCore #(
	parameter logic [31:0] RESET_PC   = 32'h8000_0000,
	parameter              DMEM_WORDS = 256
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        instValid,
	input  logic [31:0] inst,
	output logic [31:0] pc,
	output logic        retireValid,
	output logic [4:0]  retireRd,
	output logic [31:0] retireData,
	output logic        retireInvalid
);
	rvPkg::instWord_u word;

	logic [rvPkg::ALU_OP_W-1:0] aluOp;
	logic        aluSrcImm, useAuipc, regWrite;
	logic [1:0]  wbSel;
	logic        isBranch, isJal, isJalr;
	logic        memRead, memWrite, invalid;
	logic [2:0]  memFunct3;
	logic [31:0] imm;
	logic [31:0] rs1Data, rs2Data;
	logic [31:0] aluResult, linkAddr, wbData;
	logic        we; // register write, already gated by the strobe

	assign word = inst;

	instDecoder u_decoder (
		.inst      (inst),
		.aluOp     (aluOp),
		.aluSrcImm (aluSrcImm),
		.useAuipc  (useAuipc),
		.regWrite  (regWrite),
		.wbSel     (wbSel),
		.isBranch  (isBranch),
		.isJal     (isJal),
		.isJalr    (isJalr),
		.memRead   (memRead),
		.memWrite  (memWrite),
		.memFunct3 (memFunct3),
		.imm       (imm),
		.invalid   (invalid)
	);

	regFile u_regFile (
		.clk     (clk),
		.rst     (rst),
		.we      (we),
		.rs1     (word.rType.rs1),
		.rs2     (word.rType.rs2),
		.rd      (word.rType.rd),
		.wdata   (wbData),
		.rs1Data (rs1Data),
		.rs2Data (rs2Data)
	);

	aluUnit u_alu (
		.aluOp     (aluOp),
		.aluSrcImm (aluSrcImm),
		.useAuipc  (useAuipc),
		.rs1Data   (rs1Data),
		.rs2Data   (rs2Data),
		.imm       (imm),
		.pc        (pc),
		.aluResult (aluResult)
	);

	nextPcUnit #(.RESET_PC(RESET_PC)) u_nextPc (
		.clk       (clk),
		.rst       (rst),
		.instValid (instValid),
		.isBranch  (isBranch),
		.isJal     (isJal),
		.isJalr    (isJalr),
		.funct3    (word.rType.funct3),
		.rs1Data   (rs1Data),
		.rs2Data   (rs2Data),
		.imm       (imm),
		.pc        (pc),
		.linkAddr  (linkAddr)
	);

	loadStoreWriteback #(.DMEM_WORDS(DMEM_WORDS)) u_lsWb (
		.clk       (clk),
		.rst       (rst),
		.instValid (instValid),
		.memRead   (memRead),
		.memWrite  (memWrite),
		.memFunct3 (memFunct3),
		.regWrite  (regWrite),
		.wbSel     (wbSel),
		.aluResult (aluResult),
		.rs2Data   (rs2Data),
		.linkAddr  (linkAddr),
		.wbData    (wbData),
		.we        (we)
	);

	// retirement report, one cycle after the strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			retireValid   <= 1'b0;
			retireInvalid <= 1'b0;
		end else begin
			retireValid   <= instValid;
			retireInvalid <= instValid && invalid;
		end
	end

	always_ff @(posedge clk) begin
		if (instValid) begin
			retireRd   <= we ? word.rType.rd : 5'd0; // 0 means no write
			retireData <= we ? wbData : 32'd0;
		end
	end

endmodule

`default_nettype wire

//--- src/rvPkg.sv
`default_nettype none

package rvPkg;

	// one instruction word seen through each of the six base formats
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} rType;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} iType;
		struct packed {
			logic [6:0] immHi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] immLo;
			logic [6:0] opcode;
		} sType;
		struct packed {
			logic       imm12;
			logic [5:0] imm10to5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4to1;
			logic       imm11;
			logic [6:0] opcode;
		} bType;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} uType;
		struct packed {
			logic       imm20;
			logic [9:0] imm10to1;
			logic       imm11;
			logic [7:0] imm19to12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} jType;
	} instWord_u;

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	localparam ALU_OP_W = 4;

	localparam logic [ALU_OP_W-1:0] ALU_ADD   = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB   = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_SLL   = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_SLT   = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_SLTU  = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_XOR   = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SRL   = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SRA   = 4'd7;
	localparam logic [ALU_OP_W-1:0] ALU_OR    = 4'd8;
	localparam logic [ALU_OP_W-1:0] ALU_AND   = 4'd9;
	localparam logic [ALU_OP_W-1:0] ALU_PASSB = 4'd10; // lui

	// write-back source
	localparam logic [1:0] WB_ALU  = 2'd0;
	localparam logic [1:0] WB_LOAD = 2'd1;
	localparam logic [1:0] WB_LINK = 2'd2;

endpackage

`default_nettype wire
